// File: compile.f
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/mem_decoder.sv
logic/alu_decoder.sv
logic/flow_decoder.sv
logic/decode_stage.sv
tb/tb_clock_gen.sv
tb/tb_decode_stage.sv

// File: logic/alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder (
  input  logic              clk_i,
  input  isa_pkg::instr_t   instr_i,
  output logic              claim_o,
  output logic              illegal_o,
  output logic              gpr_we_o,
  output logic              branch_o,
  output ctrl_pkg::alu_op_t alu_op_o,
  output ctrl_pkg::b_sel_t  b_sel_o
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;

  assign opcode = instr_i[OPCODE_LSB +: $bits(opcode_t)];
  assign funct3 = instr_i[FUNCT3_LSB +: $bits(funct3_t)];
  assign funct7 = instr_i[FUNCT7_LSB +: $bits(funct7_t)];

  assign claim_o = opcode inside {OP_OPCODE, OP_IMM_OPCODE, BRANCH_OPCODE, MISC_MEM_OPCODE};

  always_comb begin
    illegal_o = 1'b0;
    gpr_we_o  = 1'b0;
    branch_o  = 1'b0;
    alu_op_o  = ALU_ADD;
    b_sel_o   = OP_B_RS2;
    case (opcode)
      OP_OPCODE: begin
        // register-register, funct7 and funct3 pick the operation together
        gpr_we_o = 1'b1;
        case ({funct7, funct3})
          {FUNCT7_BASE, 3'd0}: alu_op_o = ALU_ADD;
          {FUNCT7_BASE, 3'd1}: alu_op_o = ALU_SLL;
          {FUNCT7_BASE, 3'd2}: alu_op_o = ALU_SLTS;
          {FUNCT7_BASE, 3'd3}: alu_op_o = ALU_SLTU;
          {FUNCT7_BASE, 3'd4}: alu_op_o = ALU_XOR;
          {FUNCT7_BASE, 3'd5}: alu_op_o = ALU_SRL;
          {FUNCT7_BASE, 3'd6}: alu_op_o = ALU_OR;
          {FUNCT7_BASE, 3'd7}: alu_op_o = ALU_AND;
          {FUNCT7_ALT, 3'd0}:  alu_op_o = ALU_SUB;
          {FUNCT7_ALT, 3'd5}:  alu_op_o = ALU_SRA;
          default:             illegal_o = 1'b1;
        endcase
      end
      OP_IMM_OPCODE: begin
        gpr_we_o = 1'b1;
        b_sel_o  = OP_B_IMM_I;
        // upper immediate bits are only a funct7 for the shifts
        case (funct3)
          3'd0: alu_op_o = ALU_ADD;
          3'd1: begin
            alu_op_o  = ALU_SLL;
            illegal_o = (funct7 != FUNCT7_BASE);
          end
          3'd2: alu_op_o = ALU_SLTS;
          3'd3: alu_op_o = ALU_SLTU;
          3'd4: alu_op_o = ALU_XOR;
          3'd5: begin
            if (funct7 == FUNCT7_BASE) begin
              alu_op_o = ALU_SRL;
            end else if (funct7 == FUNCT7_ALT) begin
              alu_op_o = ALU_SRA;
            end else begin
              illegal_o = 1'b1;
            end
          end
          3'd6: alu_op_o = ALU_OR;
          3'd7: alu_op_o = ALU_AND;
        endcase
      end
      BRANCH_OPCODE: begin
        branch_o = 1'b1;
        case (funct3)
          3'd0:    alu_op_o = ALU_EQ;
          3'd1:    alu_op_o = ALU_NE;
          3'd4:    alu_op_o = ALU_LTS;
          3'd5:    alu_op_o = ALU_GES;
          3'd6:    alu_op_o = ALU_LTU;
          3'd7:    alu_op_o = ALU_GEU;
          default: illegal_o = 1'b1;
        endcase
      end
      MISC_MEM_OPCODE: begin
        // fence runs as a harmless AND whose result is dropped
        if (funct3 == 3'd0) begin
          alu_op_o = ALU_AND;
          b_sel_o  = OP_B_IMM_I;
        end else begin
          illegal_o = 1'b1;
        end
      end
      default: ;
    endcase
    // a bad funct field takes back every control set above
    if (illegal_o) begin
      gpr_we_o = 1'b0;
      branch_o = 1'b0;
      alu_op_o = ALU_ADD;
      b_sel_o  = OP_B_RS2;
    end
  end

  // an illegal word must neither write rd nor redirect the PC
  a_illegal_quiet: assert property (@(posedge clk_i) illegal_o |-> !gpr_we_o && !branch_o)
    else $error("alu_decoder: illegal word with gpr_we_o or branch_o set");

endmodule

// File: logic/ctrl_pkg.sv
package ctrl_pkg;

  // control bundle field types
  typedef logic [4:0] alu_op_t;
  typedef logic [1:0] a_sel_t;
  typedef logic [2:0] b_sel_t;
  typedef logic [1:0] wb_sel_t;
  // memory access size, this is funct3 of the load or store unchanged
  typedef logic [2:0] mem_size_t;

  // ALU operations, ALU_ADD must stay at zero since the top level ORs fields
  localparam alu_op_t ALU_ADD  = 5'b00000;
  localparam alu_op_t ALU_SLL  = 5'b00001;
  localparam alu_op_t ALU_SLTS = 5'b00010;
  localparam alu_op_t ALU_SLTU = 5'b00011;
  localparam alu_op_t ALU_XOR  = 5'b00100;
  localparam alu_op_t ALU_SRL  = 5'b00101;
  localparam alu_op_t ALU_OR   = 5'b00110;
  localparam alu_op_t ALU_AND  = 5'b00111;
  localparam alu_op_t ALU_SUB  = 5'b01000;
  localparam alu_op_t ALU_SRA  = 5'b01101;

  // branch compares are 11 followed by the branch funct3
  localparam alu_op_t ALU_EQ   = 5'b11000;
  localparam alu_op_t ALU_NE   = 5'b11001;
  localparam alu_op_t ALU_LTS  = 5'b11100;
  localparam alu_op_t ALU_GES  = 5'b11101;
  localparam alu_op_t ALU_LTU  = 5'b11110;
  localparam alu_op_t ALU_GEU  = 5'b11111;

  // operand A sources
  localparam a_sel_t OP_A_RS1     = 2'd0;
  localparam a_sel_t OP_A_CURR_PC = 2'd1;
  localparam a_sel_t OP_A_ZERO    = 2'd2;

  // operand B sources, OP_B_INCR is the constant 4 for the link address
  localparam b_sel_t OP_B_RS2   = 3'd0;
  localparam b_sel_t OP_B_IMM_I = 3'd1;
  localparam b_sel_t OP_B_IMM_U = 3'd2;
  localparam b_sel_t OP_B_IMM_S = 3'd3;
  localparam b_sel_t OP_B_INCR  = 3'd4;

  // register file write-back sources
  localparam wb_sel_t WB_EX_RESULT = 2'd0;
  localparam wb_sel_t WB_LSU_DATA  = 2'd1;

endpackage

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                clk_i,
  input  logic                rst_i,
  input  isa_pkg::instr_t     instr_i,
  input  logic                valid_i,
  output logic                valid_o,
  output ctrl_pkg::alu_op_t   alu_op_o,
  output ctrl_pkg::a_sel_t    a_sel_o,
  output ctrl_pkg::b_sel_t    b_sel_o,
  output ctrl_pkg::wb_sel_t   wb_sel_o,
  output ctrl_pkg::mem_size_t mem_size_o,
  output logic                gpr_we_o,
  output logic                mem_req_o,
  output logic                mem_we_o,
  output logic                branch_o,
  output logic                jal_o,
  output logic                jalr_o,
  output logic                illegal_instr_o
);
  import ctrl_pkg::*;

  // load and store decoder results
  logic      mem_claim;
  logic      mem_illegal;
  logic      mem_req;
  logic      mem_we;
  logic      mem_gpr_we;
  mem_size_t mem_size;
  wb_sel_t   mem_wb_sel;
  b_sel_t    mem_b_sel;
  // arithmetic, branch and fence decoder results
  logic      alu_claim;
  logic      alu_illegal;
  logic      alu_gpr_we;
  logic      alu_branch;
  alu_op_t   alu_op;
  b_sel_t    alu_b_sel;
  // jump and upper immediate decoder results
  logic      flow_claim;
  logic      flow_illegal;
  logic      flow_gpr_we;
  logic      flow_jal;
  logic      flow_jalr;
  a_sel_t    flow_a_sel;
  b_sel_t    flow_b_sel;
  // merged bundle ahead of the register
  logic      dec_illegal;
  logic      dec_gpr_we;
  b_sel_t    dec_b_sel;

  mem_decoder i_mem_decoder (
    .clk_i      (clk_i),
    .instr_i    (instr_i),
    .claim_o    (mem_claim),
    .illegal_o  (mem_illegal),
    .mem_req_o  (mem_req),
    .mem_we_o   (mem_we),
    .gpr_we_o   (mem_gpr_we),
    .mem_size_o (mem_size),
    .wb_sel_o   (mem_wb_sel),
    .b_sel_o    (mem_b_sel)
  );

  alu_decoder i_alu_decoder (
    .clk_i     (clk_i),
    .instr_i   (instr_i),
    .claim_o   (alu_claim),
    .illegal_o (alu_illegal),
    .gpr_we_o  (alu_gpr_we),
    .branch_o  (alu_branch),
    .alu_op_o  (alu_op),
    .b_sel_o   (alu_b_sel)
  );

  flow_decoder i_flow_decoder (
    .instr_i   (instr_i),
    .claim_o   (flow_claim),
    .illegal_o (flow_illegal),
    .gpr_we_o  (flow_gpr_we),
    .jal_o     (flow_jal),
    .jalr_o    (flow_jalr),
    .a_sel_o   (flow_a_sel),
    .b_sel_o   (flow_b_sel)
  );

  // unclaimed decoders drive zeros, so a plain OR picks the active one
  assign dec_b_sel  = mem_b_sel | alu_b_sel | flow_b_sel;
  assign dec_gpr_we = mem_gpr_we | alu_gpr_we | flow_gpr_we;

  // an opcode nobody owns covers SYSTEM, unused opcodes and bad low bits
  assign dec_illegal = !(mem_claim || alu_claim || flow_claim)
                     || mem_illegal || alu_illegal || flow_illegal;

  // decode register, an empty slot holds an all-zero bundle
  always_ff @(posedge clk_i) begin
    if (rst_i || !valid_i) begin
      valid_o         <= 1'b0;
      alu_op_o        <= ALU_ADD;
      a_sel_o         <= OP_A_RS1;
      b_sel_o         <= OP_B_RS2;
      wb_sel_o        <= WB_EX_RESULT;
      mem_size_o      <= '0;
      gpr_we_o        <= 1'b0;
      mem_req_o       <= 1'b0;
      mem_we_o        <= 1'b0;
      branch_o        <= 1'b0;
      jal_o           <= 1'b0;
      jalr_o          <= 1'b0;
      illegal_instr_o <= 1'b0;
    end else begin
      valid_o         <= 1'b1;
      alu_op_o        <= alu_op;
      a_sel_o         <= flow_a_sel;
      b_sel_o         <= dec_b_sel;
      wb_sel_o        <= mem_wb_sel;
      mem_size_o      <= mem_size;
      gpr_we_o        <= dec_gpr_we;
      mem_req_o       <= mem_req;
      mem_we_o        <= mem_we;
      branch_o        <= alu_branch;
      jal_o           <= flow_jal;
      jalr_o          <= flow_jalr;
      illegal_instr_o <= dec_illegal;
    end
  end

  // control transfer kinds come from two decoders and must never overlap
  a_one_transfer: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({branch_o, jal_o, jalr_o}))
    else $error("decode_stage: more than one control transfer flag");

  // an illegal word reaches the pipeline with every enable low
  a_illegal_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    illegal_instr_o |-> !(gpr_we_o || mem_req_o || mem_we_o || branch_o || jal_o || jalr_o))
    else $error("decode_stage: illegal word with an enable set");

  // the opcode sets of the class decoders are disjoint
  a_single_claim: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_i |-> $onehot0({mem_claim, alu_claim, flow_claim}))
    else $error("decode_stage: word claimed by more than one decoder");

endmodule

// File: logic/flow_decoder.sv
`timescale 1ns/1ps

module flow_decoder (
  input  isa_pkg::instr_t  instr_i,
  output logic             claim_o,
  output logic             illegal_o,
  output logic             gpr_we_o,
  output logic             jal_o,
  output logic             jalr_o,
  output ctrl_pkg::a_sel_t a_sel_o,
  output ctrl_pkg::b_sel_t b_sel_o
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  opcode_t opcode;
  funct3_t funct3;

  assign opcode = instr_i[OPCODE_LSB +: $bits(opcode_t)];
  assign funct3 = instr_i[FUNCT3_LSB +: $bits(funct3_t)];

  assign claim_o = opcode inside {JAL_OPCODE, JALR_OPCODE, LUI_OPCODE, AUIPC_OPCODE};

  always_comb begin
    illegal_o = 1'b0;
    gpr_we_o  = 1'b0;
    jal_o     = 1'b0;
    jalr_o    = 1'b0;
    a_sel_o   = OP_A_RS1;
    b_sel_o   = OP_B_RS2;
    case (opcode)
      JAL_OPCODE: begin
        // rd gets pc + 4, the jump target is formed outside the ALU
        jal_o    = 1'b1;
        gpr_we_o = 1'b1;
        a_sel_o  = OP_A_CURR_PC;
        b_sel_o  = OP_B_INCR;
      end
      JALR_OPCODE: begin
        if (funct3 == 3'd0) begin
          jalr_o   = 1'b1;
          gpr_we_o = 1'b1;
          a_sel_o  = OP_A_CURR_PC;
          b_sel_o  = OP_B_INCR;
        end else begin
          illegal_o = 1'b1;
        end
      end
      LUI_OPCODE: begin
        // zero plus the U immediate
        gpr_we_o = 1'b1;
        a_sel_o  = OP_A_ZERO;
        b_sel_o  = OP_B_IMM_U;
      end
      AUIPC_OPCODE: begin
        gpr_we_o = 1'b1;
        a_sel_o  = OP_A_CURR_PC;
        b_sel_o  = OP_B_IMM_U;
      end
      default: ;
    endcase
  end

endmodule

// File: logic/isa_pkg.sv
package isa_pkg;

  // a full instruction word as it leaves the fetch stage
  typedef logic [31:0] instr_t;

  // the instruction fields that the decoders look at
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // bit positions of the fields inside instr_t
  localparam int OPCODE_LSB = 0;
  localparam int FUNCT3_LSB = 12;
  localparam int FUNCT7_LSB = 25;

  // base opcodes, the low two bits are always 11 for 32-bit words
  localparam opcode_t LOAD_OPCODE     = 7'b0000011;
  localparam opcode_t MISC_MEM_OPCODE = 7'b0001111;
  localparam opcode_t OP_IMM_OPCODE   = 7'b0010011;
  localparam opcode_t AUIPC_OPCODE    = 7'b0010111;
  localparam opcode_t STORE_OPCODE    = 7'b0100011;
  localparam opcode_t OP_OPCODE       = 7'b0110011;
  localparam opcode_t LUI_OPCODE      = 7'b0110111;
  localparam opcode_t BRANCH_OPCODE   = 7'b1100011;
  localparam opcode_t JALR_OPCODE     = 7'b1100111;
  localparam opcode_t JAL_OPCODE      = 7'b1101111;
  // no decoder claims this one, so every SYSTEM word ends up illegal
  localparam opcode_t SYSTEM_OPCODE   = 7'b1110011;

  // load and store access sizes as coded in funct3
  localparam funct3_t LDST_B  = 3'd0;
  localparam funct3_t LDST_H  = 3'd1;
  localparam funct3_t LDST_W  = 3'd2;
  localparam funct3_t LDST_BU = 3'd4;
  localparam funct3_t LDST_HU = 3'd5;

  // funct7 of the plain operation and of the sub/sra variant
  localparam funct7_t FUNCT7_BASE = 7'h00;
  localparam funct7_t FUNCT7_ALT  = 7'h20;

endpackage

// File: logic/mem_decoder.sv
`timescale 1ns/1ps

module mem_decoder (
  input  logic                clk_i,
  input  isa_pkg::instr_t     instr_i,
  output logic                claim_o,
  output logic                illegal_o,
  output logic                mem_req_o,
  output logic                mem_we_o,
  output logic                gpr_we_o,
  output ctrl_pkg::mem_size_t mem_size_o,
  output ctrl_pkg::wb_sel_t   wb_sel_o,
  output ctrl_pkg::b_sel_t    b_sel_o
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  opcode_t opcode;
  funct3_t funct3;

  assign opcode = instr_i[OPCODE_LSB +: $bits(opcode_t)];
  assign funct3 = instr_i[FUNCT3_LSB +: $bits(funct3_t)];

  // this decoder owns the two memory access classes only
  assign claim_o = (opcode == LOAD_OPCODE) || (opcode == STORE_OPCODE);

  always_comb begin
    // everything idles at zero unless a legal load or store is seen
    illegal_o  = 1'b0;
    mem_req_o  = 1'b0;
    mem_we_o   = 1'b0;
    gpr_we_o   = 1'b0;
    mem_size_o = '0;
    wb_sel_o   = WB_EX_RESULT;
    b_sel_o    = OP_B_RS2;
    case (opcode)
      LOAD_OPCODE: begin
        case (funct3)
          LDST_B, LDST_H, LDST_W, LDST_BU, LDST_HU: begin
            // address is rs1 plus the I immediate, result goes to rd
            mem_req_o  = 1'b1;
            gpr_we_o   = 1'b1;
            wb_sel_o   = WB_LSU_DATA;
            b_sel_o    = OP_B_IMM_I;
            mem_size_o = mem_size_t'(funct3);
          end
          default: illegal_o = 1'b1;
        endcase
      end
      STORE_OPCODE: begin
        // stores have no unsigned sizes
        case (funct3)
          LDST_B, LDST_H, LDST_W: begin
            mem_req_o  = 1'b1;
            mem_we_o   = 1'b1;
            b_sel_o    = OP_B_IMM_S;
            mem_size_o = mem_size_t'(funct3);
          end
          default: illegal_o = 1'b1;
        endcase
      end
      default: ;
    endcase
  end

  // a write to memory is never issued without a request
  a_we_with_req: assert property (@(posedge clk_i) mem_we_o |-> mem_req_o)
    else $error("mem_decoder: mem_we_o without mem_req_o");

endmodule

// File: run.sh
#!/usr/bin/env bash
# builds the decode stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f compile.f \
    --top-module tb_decode_stage -o tb_decode_stage; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_decode_stage > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "Test completed successfully" sim.log; then
  exit 0
fi
exit 1

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);
  localparam int HALF_PERIOD_NS = 4;
  localparam int RESET_CYCLES   = 10;

  // free running 8 ns clock
  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD_NS clk_o = ~clk_o;
  end

  // reset drops 1 ns after the tenth rising edge, like any other driven input
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

// File: tb/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;
  import isa_pkg::*;
  import ctrl_pkg::*;

  localparam logic [31:0] LFSR_SEED = 32'h3b42_7a16;
  // x^32 + x^22 + x^2 + x + 1, a maximal length Galois polynomial
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam int STREAM_WORDS   = 200;
  // upper bound on the words sent by the directed tests
  localparam int DIRECTED_WORDS = 90;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_NS = ((DIRECTED_WORDS + STREAM_WORDS) * 8 + RESET_CYCLES * 8) * 2;
  localparam opcode_t LEGAL_OPCODES [10] = '{LOAD_OPCODE, MISC_MEM_OPCODE, OP_IMM_OPCODE,
    AUIPC_OPCODE, STORE_OPCODE, OP_OPCODE, LUI_OPCODE, BRANCH_OPCODE, JALR_OPCODE, JAL_OPCODE};

  // the whole control bundle as the reference model sees it
  typedef struct packed {
    alu_op_t   alu_op;
    a_sel_t    a_sel;
    b_sel_t    b_sel;
    wb_sel_t   wb_sel;
    mem_size_t mem_size;
    logic      gpr_we;
    logic      mem_req;
    logic      mem_we;
    logic      branch;
    logic      jal;
    logic      jalr;
    logic      illegal;
  } ctrl_t;

  logic      clk;
  logic      rst;
  instr_t    instr_i;
  logic      valid_i;
  logic      valid_o;
  alu_op_t   alu_op_o;
  a_sel_t    a_sel_o;
  b_sel_t    b_sel_o;
  wb_sel_t   wb_sel_o;
  mem_size_t mem_size_o;
  logic      gpr_we_o;
  logic      mem_req_o;
  logic      mem_we_o;
  logic      branch_o;
  logic      jal_o;
  logic      jalr_o;
  logic      illegal_instr_o;
  logic [31:0] lfsr_state;
  int        tests;
  int        checks;
  int        errors;

  tb_clock_gen i_clock_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  decode_stage i_dut (
    .clk_i           (clk),
    .rst_i           (rst),
    .instr_i         (instr_i),
    .valid_i         (valid_i),
    .valid_o         (valid_o),
    .alu_op_o        (alu_op_o),
    .a_sel_o         (a_sel_o),
    .b_sel_o         (b_sel_o),
    .wb_sel_o        (wb_sel_o),
    .mem_size_o      (mem_size_o),
    .gpr_we_o        (gpr_we_o),
    .mem_req_o       (mem_req_o),
    .mem_we_o        (mem_we_o),
    .branch_o        (branch_o),
    .jal_o           (jal_o),
    .jalr_o          (jalr_o),
    .illegal_instr_o (illegal_instr_o)
  );

  // reference decode written from the instruction set rules
  function automatic ctrl_t expect_ctrl(input instr_t w);
    ctrl_t   e;
    funct3_t f3;
    funct7_t f7;
    logic    ok;
    e  = '0;
    f3 = w[14:12];
    f7 = w[31:25];
    ok = 1'b1;
    case (w[6:0])
      LOAD_OPCODE: begin
        ok = f3 inside {LDST_B, LDST_H, LDST_W, LDST_BU, LDST_HU};
        e.mem_req  = ok;
        e.gpr_we   = ok;
        e.wb_sel   = ok ? WB_LSU_DATA : WB_EX_RESULT;
        e.b_sel    = ok ? OP_B_IMM_I : OP_B_RS2;
        e.mem_size = ok ? f3 : 3'd0;
      end
      STORE_OPCODE: begin
        ok = f3 inside {LDST_B, LDST_H, LDST_W};
        e.mem_req  = ok;
        e.mem_we   = ok;
        e.b_sel    = ok ? OP_B_IMM_S : OP_B_RS2;
        e.mem_size = ok ? f3 : 3'd0;
      end
      OP_OPCODE: begin
        // the alt funct7 only exists for sub and sra, and sets bit 3 of the op
        ok = (f7 == FUNCT7_BASE) || (f7 == FUNCT7_ALT && (f3 == 3'd0 || f3 == 3'd5));
        e.gpr_we = ok;
        e.alu_op = ok ? {1'b0, f7 == FUNCT7_ALT, f3} : ALU_ADD;
      end
      OP_IMM_OPCODE: begin
        ok = !(f3 == 3'd1 && f7 != FUNCT7_BASE)
          && !(f3 == 3'd5 && f7 != FUNCT7_BASE && f7 != FUNCT7_ALT);
        e.gpr_we = ok;
        e.b_sel  = ok ? OP_B_IMM_I : OP_B_RS2;
        e.alu_op = ok ? {1'b0, f3 == 3'd5 && f7 == FUNCT7_ALT, f3} : ALU_ADD;
      end
      BRANCH_OPCODE: begin
        ok = (f3 != 3'd2) && (f3 != 3'd3);
        e.branch = ok;
        e.alu_op = ok ? {2'b11, f3} : ALU_ADD;
      end
      MISC_MEM_OPCODE: begin
        ok = (f3 == 3'd0);
        e.alu_op = ok ? ALU_AND : ALU_ADD;
        e.b_sel  = ok ? OP_B_IMM_I : OP_B_RS2;
      end
      JAL_OPCODE, JALR_OPCODE: begin
        ok = (w[6:0] == JAL_OPCODE) || (f3 == 3'd0);
        e.jal    = ok && (w[6:0] == JAL_OPCODE);
        e.jalr   = ok && (w[6:0] == JALR_OPCODE);
        e.gpr_we = ok;
        e.a_sel  = ok ? OP_A_CURR_PC : OP_A_RS1;
        e.b_sel  = ok ? OP_B_INCR : OP_B_RS2;
      end
      LUI_OPCODE, AUIPC_OPCODE: begin
        e.gpr_we = 1'b1;
        e.a_sel  = (w[6:0] == LUI_OPCODE) ? OP_A_ZERO : OP_A_CURR_PC;
        e.b_sel  = OP_B_IMM_U;
      end
      default: ok = 1'b0;
    endcase
    e.illegal = !ok;
    return e;
  endfunction

  function automatic instr_t make_word(input funct7_t f7, input funct3_t f3, input opcode_t opc);
    return {f7, 5'd7, 5'd6, f3, 5'd5, opc};
  endfunction

  // one Galois step, the bit shifted out is the random bit
  function automatic logic lfsr_step();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ LFSR_TAPS;
    end
    return out;
  endfunction

  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (exp == got) else begin
      errors++;
      $display("FAIL %s expected 0x%0h got 0x%0h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic check_bundle(input ctrl_t e, input logic exp_valid);
    check_field("valid_o", 32'(exp_valid), 32'(valid_o));
    check_field("alu_op_o", 32'(e.alu_op), 32'(alu_op_o));
    check_field("a_sel_o", 32'(e.a_sel), 32'(a_sel_o));
    check_field("b_sel_o", 32'(e.b_sel), 32'(b_sel_o));
    check_field("wb_sel_o", 32'(e.wb_sel), 32'(wb_sel_o));
    check_field("mem_size_o", 32'(e.mem_size), 32'(mem_size_o));
    check_field("gpr_we_o", 32'(e.gpr_we), 32'(gpr_we_o));
    check_field("mem_req_o", 32'(e.mem_req), 32'(mem_req_o));
    check_field("mem_we_o", 32'(e.mem_we), 32'(mem_we_o));
    check_field("branch_o", 32'(e.branch), 32'(branch_o));
    check_field("jal_o", 32'(e.jal), 32'(jal_o));
    check_field("jalr_o", 32'(e.jalr), 32'(jalr_o));
    check_field("illegal_instr_o", 32'(e.illegal), 32'(illegal_instr_o));
  endtask

  // called 1 ns after an edge, so calls in a row feed one word per cycle
  task automatic send_word(input instr_t w, input logic v);
    instr_i = w;
    valid_i = v;
    @(posedge clk);
    #1;
    check_bundle(v ? expect_ctrl(w) : ctrl_t'('0), v);
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    $display("test %-14s %s, %0d errors", name, (errors == err0) ? "passed" : "FAILED",
             errors - err0);
  endtask

  task automatic test_reset_and_valid();
    int err0;
    err0 = errors;
    // a valid jal during reset must leave the register empty
    @(posedge clk);
    #1;
    instr_i = make_word(7'h00, 3'd0, JAL_OPCODE);
    valid_i = 1'b1;
    @(posedge clk);
    #1;
    check_bundle('0, 1'b0);
    valid_i = 1'b0;
    wait (!rst);
    send_word(make_word(7'h00, 3'd0, JAL_OPCODE), 1'b0);
    send_word(make_word(7'h00, 3'd0, LUI_OPCODE), 1'b1);
    send_word(make_word(7'h00, 3'd0, LUI_OPCODE), 1'b0);
    end_test("reset_valid", err0);
  endtask

  task automatic test_alu_words();
    int err0;
    err0 = errors;
    for (int f3 = 0; f3 < 8; f3++) begin
      send_word(make_word(FUNCT7_BASE, funct3_t'(f3), OP_OPCODE), 1'b1);
      send_word(make_word(FUNCT7_BASE, funct3_t'(f3), OP_IMM_OPCODE), 1'b1);
    end
    send_word(make_word(FUNCT7_ALT, 3'd0, OP_OPCODE), 1'b1);
    send_word(make_word(FUNCT7_ALT, 3'd5, OP_OPCODE), 1'b1);
    send_word(make_word(FUNCT7_ALT, 3'd5, OP_IMM_OPCODE), 1'b1);
    // funct7 is immediate data for addi, so anything goes there
    send_word(make_word(7'h55, 3'd0, OP_IMM_OPCODE), 1'b1);
    // bad funct7 on register ops and immediate shifts
    send_word(make_word(FUNCT7_ALT, 3'd1, OP_OPCODE), 1'b1);
    send_word(make_word(7'h01, 3'd0, OP_OPCODE), 1'b1);
    send_word(make_word(FUNCT7_ALT, 3'd1, OP_IMM_OPCODE), 1'b1);
    send_word(make_word(7'h7f, 3'd5, OP_IMM_OPCODE), 1'b1);
    end_test("alu_words", err0);
  endtask

  task automatic test_mem_words();
    int err0;
    err0 = errors;
    for (int f3 = 0; f3 < 8; f3++) begin
      send_word(make_word(7'h12, funct3_t'(f3), LOAD_OPCODE), 1'b1);
      send_word(make_word(7'h12, funct3_t'(f3), STORE_OPCODE), 1'b1);
    end
    end_test("mem_words", err0);
  endtask

  task automatic test_flow_words();
    int err0;
    err0 = errors;
    for (int f3 = 0; f3 < 8; f3++) begin
      send_word(make_word(7'h40, funct3_t'(f3), BRANCH_OPCODE), 1'b1);
      send_word(make_word(7'h00, funct3_t'(f3), JALR_OPCODE), 1'b1);
    end
    send_word(make_word(7'h3a, 3'd6, JAL_OPCODE), 1'b1);
    send_word(make_word(7'h7f, 3'd3, LUI_OPCODE), 1'b1);
    send_word(make_word(7'h01, 3'd2, AUIPC_OPCODE), 1'b1);
    send_word(make_word(7'h0f, 3'd0, MISC_MEM_OPCODE), 1'b1);
    send_word(make_word(7'h00, 3'd1, MISC_MEM_OPCODE), 1'b1);
    end_test("flow_words", err0);
  endtask

  task automatic test_illegal_words();
    int err0;
    err0 = errors;
    // ecall, mret and csrrw are all gone with the SYSTEM class
    send_word(32'h0000_0073, 1'b1);
    send_word(32'h3020_0073, 1'b1);
    send_word(make_word(7'h18, 3'd1, SYSTEM_OPCODE), 1'b1);
    // addi and jal with the low two bits broken
    send_word(32'h0000_0012, 1'b1);
    send_word(32'h0000_0011, 1'b1);
    send_word(32'h0000_006c, 1'b1);
    send_word(make_word(7'h00, 3'd2, 7'b0101111), 1'b1);
    send_word(make_word(7'h00, 3'd0, 7'b1010011), 1'b1);
    send_word(32'hffff_ffff, 1'b1);
    send_word(32'h0000_0000, 1'b1);
    end_test("illegal_words", err0);
  endtask

  task automatic test_random_stream();
    int          err0;
    int          idx;
    funct3_t     f3;
    funct7_t     f7;
    logic [31:0] regs;
    err0 = errors;
    for (int n = 0; n < STREAM_WORDS; n++) begin
      idx = int'(draw_bits(4) % 10);
      f3  = funct3_t'(draw_bits(3));
      // half the words get a base or alt funct7 so OP words are often legal
      if (draw_bits(1) != 0) begin
        f7 = funct7_t'(draw_bits(7));
      end else begin
        f7 = (draw_bits(1) != 0) ? FUNCT7_ALT : FUNCT7_BASE;
      end
      regs = draw_bits(15);
      send_word({f7, regs[14:5], f3, regs[4:0], LEGAL_OPCODES[idx]}, 1'b1);
    end
    end_test("random_stream", err0);
  endtask

  initial begin
    instr_i    = '0;
    valid_i    = 1'b0;
    lfsr_state = LFSR_SEED;
    tests      = 0;
    checks     = 0;
    errors     = 0;
    test_reset_and_valid();
    test_alu_words();
    test_mem_words();
    test_flow_words();
    test_illegal_words();
    test_random_stream();
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog sized at twice the time the tests need
  initial begin
    #TIMEOUT_NS;
    $display("watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
    $display("Test failed");
    $finish;
  end

endmodule
